// ==== sys_defines.svh ====
`ifndef SYS_DEFINES_SVH
`define SYS_DEFINES_SVH

// Bus widths
`define SYS_WORD_BITS 32 // Data word
`define SYS_ADDR_BITS 32 // Byte address

// RAM size as word index bits
`define SYS_RAM_ADDR_BITS 8 // 256 words, index from addr[2] up

// Master slots in request and grant vectors
`define SYS_BUS_DATA 0 // Data side wins ties
`define SYS_BUS_INSN 1 // Instruction side
`define SYS_NUM_MASTERS 2 // Vector width

`endif

// ==== sys_pkg.sv ====
`default_nettype none
`include "sys_defines.svh"

package sys_pkg;

	typedef logic [`SYS_WORD_BITS-1:0] word_t; // Data word
	typedef logic [`SYS_ADDR_BITS-1:0] addr_t; // Byte address
	typedef logic [`SYS_RAM_ADDR_BITS-1:0] ram_index_t; // RAM word index
	typedef logic [`SYS_NUM_MASTERS-1:0] master_vec_t; // One bit per master

	// Master side of the shared bus, all zero when not granted
	typedef struct packed {
		addr_t addr; // Byte address
		word_t wdata; // Write payload
		logic rd; // Read strobe
		logic wr; // Write strobe
	} bus_cmd_t;

	// Slave side, all zero outside a ready cycle
	typedef struct packed {
		word_t rdata; // Read payload
		logic ready; // One-cycle completion pulse
	} bus_resp_t;

	typedef enum logic [1:0] {
		FETCH_IDLE, // Waiting, hits answered here
		FETCH_REQ, // Bus requested
		FETCH_BUS // Strobe issued, waiting for ready
	} fetch_state_t;

	typedef enum logic [1:0] {
		DATA_IDLE, // No access in flight
		DATA_REQ, // Bus requested
		DATA_BUS // Strobe issued, waiting for ready
	} data_state_t;

	typedef enum logic [1:0] {
		OWN_NONE, // Bus free
		OWN_DATA, // Data port holds bus
		OWN_INSN // Instruction port holds bus
	} owner_t;

endpackage

`default_nettype wire

// ==== ifetch_port.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "sys_defines.svh"

module ifetch_port (
	input wire clk,
	input wire rst,
	input wire ic_rd_req, // Held until wait drops
	input wire sys_pkg::addr_t ic_rd_addr,
	output logic ic_rd_wait,
	output sys_pkg::word_t ic_rd_data,
	output logic bus_req,
	input wire bus_ack,
	output sys_pkg::bus_cmd_t bus_cmd,
	input wire sys_pkg::bus_cmd_t bus_snoop, // Merged bus command, watched for writes
	input wire sys_pkg::bus_resp_t bus_resp
);

	sys_pkg::fetch_state_t state_q; // FSM state
	sys_pkg::addr_t tag_q; // Address of buffered word
	sys_pkg::word_t data_q; // Buffered instruction
	logic valid_q; // Buffer holds a good copy
	logic hit; // Request served from buffer
	logic done; // Bus fetch completes this cycle
	logic snoop_hit; // Bus write to buffered word

	// Word compare, byte offset ignored
	assign hit = ic_rd_req && valid_q
		&& (ic_rd_addr[`SYS_ADDR_BITS-1:2] == tag_q[`SYS_ADDR_BITS-1:2]);
	assign snoop_hit = bus_snoop.wr
		&& (bus_snoop.addr[`SYS_ADDR_BITS-1:2] == tag_q[`SYS_ADDR_BITS-1:2]);
	assign done = (state_q == sys_pkg::FETCH_BUS) && bus_resp.ready;

	assign ic_rd_wait = ic_rd_req && !hit && !done; // Low on hit or ready
	assign ic_rd_data = done ? bus_resp.rdata : data_q; // Bus word bypasses buffer
	assign bus_req = (state_q != sys_pkg::FETCH_IDLE); // Held through ready cycle

	always_comb
	begin
		bus_cmd = '0; // Silent unless granted
		if ((state_q == sys_pkg::FETCH_REQ) && bus_ack)
		begin
			bus_cmd.addr = tag_q; // Missed address
			bus_cmd.rd = 1'b1; // Single strobe cycle
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state_q <= sys_pkg::FETCH_IDLE;
			valid_q <= 1'b0; // Buffer starts empty
		end
		else
		begin
			case (state_q)
				sys_pkg::FETCH_IDLE:
					if (ic_rd_req && !hit)
					begin
						state_q <= sys_pkg::FETCH_REQ; // Miss
						valid_q <= 1'b0; // Tag about to change
					end
				sys_pkg::FETCH_REQ:
					if (bus_ack)
						state_q <= sys_pkg::FETCH_BUS; // Strobe went out
				sys_pkg::FETCH_BUS:
					if (bus_resp.ready)
					begin
						state_q <= sys_pkg::FETCH_IDLE;
						valid_q <= 1'b1; // Refilled
					end
				default:
					state_q <= sys_pkg::FETCH_IDLE;
			endcase
			if (snoop_hit)
				valid_q <= 1'b0; // Stale copy dropped
		end
	end

	// Buffer payload
	always_ff @(posedge clk)
	begin
		if ((state_q == sys_pkg::FETCH_IDLE) && ic_rd_req && !hit)
			tag_q <= ic_rd_addr; // Tag also serves as fetch address
		if (done)
			data_q <= bus_resp.rdata;
	end

endmodule

`default_nettype wire

// ==== data_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_port (
	input wire clk,
	input wire rst,
	input wire dc_rd_req, // At most one of rd/wr high
	input wire dc_wr_req,
	input wire sys_pkg::addr_t dc_addr,
	input wire sys_pkg::word_t dc_wr_data,
	output logic dc_rw_wait,
	output sys_pkg::word_t dc_rd_data,
	output logic bus_req,
	input wire bus_ack,
	output sys_pkg::bus_cmd_t bus_cmd,
	input wire sys_pkg::bus_resp_t bus_resp
);

	sys_pkg::data_state_t state_q; // FSM state
	sys_pkg::addr_t addr_q; // Latched access address
	sys_pkg::word_t wdata_q; // Latched write data
	logic wr_q; // Access is a write
	logic start; // New access accepted
	logic done; // Ready for our access

	assign start = (state_q == sys_pkg::DATA_IDLE) && (dc_rd_req || dc_wr_req);
	assign done = (state_q == sys_pkg::DATA_BUS) && bus_resp.ready;

	assign dc_rw_wait = (dc_rd_req || dc_wr_req) && !done; // Low when idle
	assign dc_rd_data = bus_resp.rdata; // Straight from slave, good when done
	assign bus_req = (state_q != sys_pkg::DATA_IDLE);

	always_comb
	begin
		bus_cmd = '0; // Zero keeps OR merge clean
		if ((state_q == sys_pkg::DATA_REQ) && bus_ack)
		begin
			bus_cmd.addr = addr_q;
			bus_cmd.wdata = wr_q ? wdata_q : '0;
			bus_cmd.rd = !wr_q;
			bus_cmd.wr = wr_q;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			state_q <= sys_pkg::DATA_IDLE;
		else
		begin
			case (state_q)
				sys_pkg::DATA_IDLE:
					if (start)
						state_q <= sys_pkg::DATA_REQ;
				sys_pkg::DATA_REQ:
					if (bus_ack)
						state_q <= sys_pkg::DATA_BUS; // Strobe issued
				sys_pkg::DATA_BUS:
					if (bus_resp.ready)
						state_q <= sys_pkg::DATA_IDLE; // Request drops next cycle
				default:
					state_q <= sys_pkg::DATA_IDLE;
			endcase
		end
	end

	// Access capture
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			addr_q <= dc_addr;
			wdata_q <= dc_wr_data;
			wr_q <= dc_wr_req;
		end
	end

endmodule

`default_nettype wire

// ==== bus_interconnect.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "sys_defines.svh"

module bus_interconnect (
	input wire clk,
	input wire rst,
	input wire sys_pkg::master_vec_t bus_req, // Level per master
	output sys_pkg::master_vec_t bus_ack, // Grant per master
	input wire sys_pkg::bus_cmd_t data_cmd,
	input wire sys_pkg::bus_cmd_t insn_cmd,
	output sys_pkg::bus_cmd_t bus_cmd, // Shared command to slave and snoop
	input wire sys_pkg::bus_resp_t ram_resp,
	output sys_pkg::bus_resp_t bus_resp // Shared response to masters
);

	sys_pkg::owner_t owner_q; // Current bus owner
	sys_pkg::owner_t owner_d;
	logic owner_keep; // Owner still requesting

	always_comb
	begin
		case (owner_q)
			sys_pkg::OWN_DATA: owner_keep = bus_req[`SYS_BUS_DATA];
			sys_pkg::OWN_INSN: owner_keep = bus_req[`SYS_BUS_INSN];
			default: owner_keep = 1'b0;
		endcase
	end

	// Fixed priority, only when the bus is released
	always_comb
	begin
		owner_d = owner_q;
		if (!owner_keep)
		begin
			if (bus_req[`SYS_BUS_DATA])
				owner_d = sys_pkg::OWN_DATA; // Lowest index first
			else if (bus_req[`SYS_BUS_INSN])
				owner_d = sys_pkg::OWN_INSN;
			else
				owner_d = sys_pkg::OWN_NONE;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			owner_q <= sys_pkg::OWN_NONE;
		else
			owner_q <= owner_d; // Grant shows one cycle after request
	end

	always_comb
	begin
		bus_ack = '0;
		bus_ack[`SYS_BUS_DATA] = (owner_q == sys_pkg::OWN_DATA);
		bus_ack[`SYS_BUS_INSN] = (owner_q == sys_pkg::OWN_INSN);
	end

	// Non-granted master drives zeros, so OR is a mux
	assign bus_cmd = data_cmd | insn_cmd;

	// Single slave, response fans out to both masters
	assign bus_resp = ram_resp;

endmodule

`default_nettype wire

// ==== block_ram.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "sys_defines.svh"

module block_ram (
	input wire clk,
	input wire sys_pkg::bus_cmd_t bus_cmd,
	output sys_pkg::bus_resp_t bus_resp
);

	sys_pkg::word_t mem [0:(1 << `SYS_RAM_ADDR_BITS)-1]; // Word storage
	sys_pkg::ram_index_t index; // Word index of access
	logic strobe; // Accepted access this cycle

	assign index = bus_cmd.addr[`SYS_RAM_ADDR_BITS+1:2]; // Drop byte offset
	assign strobe = (bus_cmd.rd || bus_cmd.wr) && !bus_resp.ready; // Ignore held strobe

	always_ff @(posedge clk)
	begin
		if (strobe && bus_cmd.wr)
			mem[index] <= bus_cmd.wdata;
	end

	// Ready pulse and read data one cycle after strobe
	always_ff @(posedge clk)
	begin
		bus_resp.ready <= strobe;
		bus_resp.rdata <= (strobe && bus_cmd.rd) ? mem[index] : '0; // Zero for OR merge
	end

endmodule

`default_nettype wire

// ==== mem_system.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "sys_defines.svh"

module mem_system (
	input wire clk,
	input wire rst,
	input wire ic_rd_req,
	input wire sys_pkg::addr_t ic_rd_addr,
	output wire ic_rd_wait,
	output wire sys_pkg::word_t ic_rd_data,
	input wire dc_rd_req,
	input wire dc_wr_req,
	input wire sys_pkg::addr_t dc_addr,
	input wire sys_pkg::word_t dc_wr_data,
	output wire dc_rw_wait,
	output wire sys_pkg::word_t dc_rd_data
);

	wire sys_pkg::master_vec_t bus_req; // Built from both masters
	wire sys_pkg::master_vec_t bus_ack;
	wire sys_pkg::bus_cmd_t data_cmd;
	wire sys_pkg::bus_cmd_t insn_cmd;
	wire sys_pkg::bus_cmd_t bus_cmd; // Merged command
	wire sys_pkg::bus_resp_t ram_resp;
	wire sys_pkg::bus_resp_t bus_resp; // Merged response

	ifetch_port i_ifetch_port (
		.clk(clk),
		.rst(rst),
		.ic_rd_req(ic_rd_req),
		.ic_rd_addr(ic_rd_addr),
		.ic_rd_wait(ic_rd_wait),
		.ic_rd_data(ic_rd_data),
		.bus_req(bus_req[`SYS_BUS_INSN]),
		.bus_ack(bus_ack[`SYS_BUS_INSN]),
		.bus_cmd(insn_cmd),
		.bus_snoop(bus_cmd), // Sees data port writes
		.bus_resp(bus_resp)
	);

	data_port i_data_port (
		.clk(clk),
		.rst(rst),
		.dc_rd_req(dc_rd_req),
		.dc_wr_req(dc_wr_req),
		.dc_addr(dc_addr),
		.dc_wr_data(dc_wr_data),
		.dc_rw_wait(dc_rw_wait),
		.dc_rd_data(dc_rd_data),
		.bus_req(bus_req[`SYS_BUS_DATA]),
		.bus_ack(bus_ack[`SYS_BUS_DATA]),
		.bus_cmd(data_cmd),
		.bus_resp(bus_resp)
	);

	bus_interconnect i_bus_interconnect (
		.clk(clk),
		.rst(rst),
		.bus_req(bus_req),
		.bus_ack(bus_ack),
		.data_cmd(data_cmd),
		.insn_cmd(insn_cmd),
		.bus_cmd(bus_cmd),
		.ram_resp(ram_resp),
		.bus_resp(bus_resp)
	);

	block_ram i_block_ram (
		.clk(clk),
		.bus_cmd(bus_cmd),
		.bus_resp(ram_resp)
	);

endmodule

`default_nettype wire

// ==== mem_system_props.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "sys_defines.svh"

module mem_system_props (
	input wire clk,
	input wire rst,
	input wire sys_pkg::master_vec_t bus_req,
	input wire sys_pkg::master_vec_t bus_ack,
	input wire sys_pkg::bus_cmd_t bus_cmd,
	input wire sys_pkg::bus_resp_t bus_resp
);

	int fail_cnt = 0; // Assertion failures so far

	a_grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(bus_ack))
		else
		begin
			$error("More than one master granted");
			fail_cnt++;
		end

	a_strobe_excl: assert property (@(posedge clk) disable iff (rst)
		!(bus_cmd.rd && bus_cmd.wr))
		else
		begin
			$error("Read and write strobe together");
			fail_cnt++;
		end

	// Owner keeps the bus while it still asks
	a_hold_data: assert property (@(posedge clk) disable iff (rst)
		bus_ack[`SYS_BUS_DATA] && bus_req[`SYS_BUS_DATA] |=> bus_ack[`SYS_BUS_DATA])
		else
		begin
			$error("Data grant moved during transaction");
			fail_cnt++;
		end

	a_hold_insn: assert property (@(posedge clk) disable iff (rst)
		bus_ack[`SYS_BUS_INSN] && bus_req[`SYS_BUS_INSN] |=> bus_ack[`SYS_BUS_INSN])
		else
		begin
			$error("Instruction grant moved during transaction");
			fail_cnt++;
		end

	a_ready_pulse: assert property (@(posedge clk) disable iff (rst)
		bus_resp.ready |=> !bus_resp.ready)
		else
		begin
			$error("Ready high two cycles in a row");
			fail_cnt++;
		end

endmodule

bind bus_interconnect mem_system_props i_mem_system_props (
	.clk(clk),
	.rst(rst),
	.bus_req(bus_req),
	.bus_ack(bus_ack),
	.bus_cmd(bus_cmd),
	.bus_resp(bus_resp)
);

`default_nettype wire

// ==== tb_mem_system.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "sys_defines.svh"

module tb_mem_system;

	localparam int NUM_WORDS = 1 << `SYS_RAM_ADDR_BITS; // RAM depth
	localparam int NUM_OPS = 3000; // Contention ops over both ports
	localparam int TIMEOUT_CYCLES = NUM_WORDS * 8 + NUM_OPS * 20;

	logic clk = 1'b0;
	logic rst;
	logic ic_rd_req;
	sys_pkg::addr_t ic_rd_addr;
	wire ic_rd_wait;
	wire sys_pkg::word_t ic_rd_data;
	logic dc_rd_req;
	logic dc_wr_req;
	sys_pkg::addr_t dc_addr;
	sys_pkg::word_t dc_wr_data;
	wire dc_rw_wait;
	wire sys_pkg::word_t dc_rd_data;

	sys_pkg::word_t model [0:NUM_WORDS-1]; // Expected RAM contents
	logic [31:0] seed; // Sequential phases
	logic [31:0] dc_seed; // Data stream in contention phase
	logic [31:0] ic_seed; // Instruction stream in contention phase
	int word_errs = 0;
	int wait_errs = 0;
	int cycle_cnt = 0;

	mem_system i_mem_system (
		.clk(clk),
		.rst(rst),
		.ic_rd_req(ic_rd_req),
		.ic_rd_addr(ic_rd_addr),
		.ic_rd_wait(ic_rd_wait),
		.ic_rd_data(ic_rd_data),
		.dc_rd_req(dc_rd_req),
		.dc_wr_req(dc_wr_req),
		.dc_addr(dc_addr),
		.dc_wr_data(dc_wr_data),
		.dc_rw_wait(dc_rw_wait),
		.dc_rd_data(dc_rd_data)
	);

	always #10 clk = ~clk; // 20 ns period

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic sys_pkg::addr_t word_addr(input sys_pkg::ram_index_t idx);
		return sys_pkg::addr_t'({idx, 2'b00}); // Word aligned, upper bits zero
	endfunction

	// Half the picks land in a 16-word window, to provoke hits and snoops
	function automatic sys_pkg::ram_index_t pick_index(input logic [31:0] r);
		return r[27] ? sys_pkg::ram_index_t'(r[19:16]) : sys_pkg::ram_index_t'(r[23:16]);
	endfunction

	task automatic check_word(input sys_pkg::word_t got, input sys_pkg::word_t exp,
		input string what);
		if (got !== exp)
		begin
			word_errs++;
			$display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_wait(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			wait_errs++;
			$display("ERR %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	// One data access, held until dc_rw_wait falls
	task automatic dc_op(input logic wr, input sys_pkg::ram_index_t idx,
		input sys_pkg::word_t d);
		@(posedge clk);
		dc_rd_req <= !wr;
		dc_wr_req <= wr;
		dc_addr <= word_addr(idx);
		dc_wr_data <= d;
		@(negedge clk);
		while (dc_rw_wait)
			@(negedge clk);
		if (wr)
			model[idx] = d; // Write is done in this cycle
		else
			check_word(dc_rd_data, model[idx], "data read");
		@(posedge clk);
		dc_rd_req <= 1'b0;
		dc_wr_req <= 1'b0;
	endtask

	// One instruction read, first_wait tells hit (0) from miss (1)
	task automatic ic_read(input sys_pkg::ram_index_t idx, output logic first_wait);
		@(posedge clk);
		ic_rd_req <= 1'b1;
		ic_rd_addr <= word_addr(idx);
		@(negedge clk);
		first_wait = ic_rd_wait;
		while (ic_rd_wait)
			@(negedge clk);
		check_word(ic_rd_data, model[idx], "instruction read");
		@(posedge clk);
		ic_rd_req <= 1'b0;
	endtask

	// Wait levels without a request, from the first cycle out of reset
	always @(negedge clk)
	begin
		if (!rst)
		begin
			if (!ic_rd_req)
				check_wait(ic_rd_wait, 1'b0, "idle ic_rd_wait");
			if (!dc_rd_req && !dc_wr_req)
				check_wait(dc_rw_wait, 1'b0, "idle dc_rw_wait");
		end
	end

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES)
		begin
			$display("Timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
			$display("Test FAILED");
			$finish;
		end
	end

	initial
	begin
		logic first_wait;
		int prop_errs; // Failures of the bound bus assertions
		int total_errs;
		rst = 1'b1;
		ic_rd_req = 1'b0;
		ic_rd_addr = '0;
		dc_rd_req = 1'b0;
		dc_wr_req = 1'b0;
		dc_addr = '0;
		dc_wr_data = '0;
		seed = 32'h2d5f;
		repeat (16) @(posedge clk);
		rst <= 1'b0;

		for (int i = 0; i < NUM_WORDS; i++)
		begin
			seed = lcg(seed);
			dc_op(1'b1, sys_pkg::ram_index_t'(i), seed); // Fill every word
		end
		for (int i = 0; i < NUM_WORDS; i++)
			dc_op(1'b0, sys_pkg::ram_index_t'(i), '0);

		repeat (64)
		begin
			seed = lcg(seed);
			ic_read(sys_pkg::ram_index_t'(seed >> 16), first_wait); // Mostly misses
		end

		// Same address twice, second one served from the buffer
		ic_read(8'h2a, first_wait);
		ic_read(8'h2a, first_wait);
		check_wait(first_wait, 1'b0, "buffer hit wait");

		// Write through the data port must kill the buffered copy
		seed = lcg(seed);
		dc_op(1'b1, 8'h2a, seed);
		ic_read(8'h2a, first_wait);
		check_wait(first_wait, 1'b1, "snooped read wait");

		dc_seed = lcg(seed);
		ic_seed = lcg(dc_seed ^ 32'h5a5a);
		fork
			repeat (NUM_OPS / 2)
			begin
				dc_seed = lcg(dc_seed);
				dc_op(dc_seed[31], pick_index(dc_seed), lcg(dc_seed));
			end
			repeat (NUM_OPS / 2)
			begin
				ic_seed = lcg(ic_seed);
				ic_read(pick_index(ic_seed), first_wait);
			end
		join

		repeat (4) @(posedge clk);
		prop_errs = i_mem_system.i_bus_interconnect.i_mem_system_props.fail_cnt;
		total_errs = word_errs + wait_errs + prop_errs;
		$display("Errors: data %0d, wait %0d, assert %0d, total %0d", word_errs, wait_errs,
			prop_errs, total_errs);
		if (total_errs == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== mem_system.f ====
+incdir+.
sys_pkg.sv
ifetch_port.sv
data_port.sv
bus_interconnect.sv
block_ram.sv
mem_system.sv
mem_system_props.sv
tb_mem_system.sv
